// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= FibonacciDatapathTb
FILELIST ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_TEXT ?= TEST RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# The simulation passes only if the pass message shows up in its output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== src.f ====
src/DatapathPkg.sv
src/RegPortIf.sv
src/RegisterFile.sv
src/Alu.sv
src/ProgramSequencer.sv
src/HexDisplayDriver.sv
src/FibonacciDatapath.sv
verification/FibonacciDatapathTb.sv

// ==== src/Alu.sv ====
module Alu
(
	RegPortIf.operand Operands,
	input DatapathPkg::AluOp Op,
	input DatapathPkg::Immediate Imm,
	output DatapathPkg::AluFlags Flags
);

	DatapathPkg::Word operandA;
	DatapathPkg::Word operandB;
	DatapathPkg::Word result;
	logic [DatapathPkg::DataWidth:0] wide;
	logic carry;
	logic overflow;

	always_comb
	begin
		operandA = Operands.DataA;
		// ADDI takes the zero-extended immediate in place of port B
		operandB = (Op == DatapathPkg::ADDI) ? DatapathPkg::Word'(Imm) : Operands.DataB;
		wide = '0;
		result = '0;
		carry = 1'b0;
		overflow = 1'b0;

		case (Op)
			DatapathPkg::ADD, DatapathPkg::ADDI:
			begin
				wide = {1'b0, operandA} + {1'b0, operandB};
				result = wide[DatapathPkg::SignBit:0];
				carry = wide[DatapathPkg::DataWidth];
				overflow = (operandA[DatapathPkg::SignBit] == operandB[DatapathPkg::SignBit])
					&& (result[DatapathPkg::SignBit] != operandA[DatapathPkg::SignBit]);
			end
			DatapathPkg::SUB:
			begin
				// Top bit of the widened difference is the borrow
				wide = {1'b0, operandA} - {1'b0, operandB};
				result = wide[DatapathPkg::SignBit:0];
				carry = wide[DatapathPkg::DataWidth];
				overflow = (operandA[DatapathPkg::SignBit] != operandB[DatapathPkg::SignBit])
					&& (result[DatapathPkg::SignBit] != operandA[DatapathPkg::SignBit]);
			end
			DatapathPkg::AND: result = operandA & operandB;
			DatapathPkg::OR: result = operandA | operandB;
			DatapathPkg::XOR: result = operandA ^ operandB;
			DatapathPkg::SHL:
			begin
				result = operandA << 1;
				carry = operandA[DatapathPkg::SignBit];
			end
			DatapathPkg::SHR:
			begin
				result = operandA >> 1;
				carry = operandA[0];
			end
			default: result = '0;
		endcase

		Operands.WriteData = result;
		Flags.Carry = carry;
		Flags.Zero = (result == '0);
		Flags.Negative = result[DatapathPkg::SignBit];
		Flags.Overflow = overflow;
	end

endmodule

// ==== src/DatapathPkg.sv ====
package DatapathPkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int DataWidth = 16;
	localparam int SignBit = DataWidth - 1;
	localparam int RegAddrWidth = 4;
	localparam int RegCount = 1 << RegAddrWidth;
	localparam int ImmWidth = 8;
	localparam int ProgramLength = 24;
	localparam int StepWidth = $clog2(ProgramLength);

	// Each display digit is held for 2**RefreshBits cycles
	localparam int RefreshBits = 8;

	typedef logic [DataWidth-1:0] Word;
	typedef logic [RegAddrWidth-1:0] RegAddr;
	typedef logic [ImmWidth-1:0] Immediate;
	typedef logic [StepWidth-1:0] StepIndex;

	////////////////////////////////////////////////////////////////////////////
	// Opcodes, sequencer states and flags
	////////////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0]
	{
		ADD,
		ADDI,
		SUB,
		AND,
		OR,
		XOR,
		SHL,
		SHR
	} AluOp;

	typedef enum logic
	{
		RUN,
		DONE
	} SeqState;

	// Carry doubles as borrow for SUB and as the shifted-out bit for shifts
	typedef struct packed
	{
		logic Carry;
		logic Zero;
		logic Negative;
		logic Overflow;
	} AluFlags;

endpackage

// ==== src/FibonacciDatapath.sv ====
module FibonacciDatapath
(
	input logic Clk,
	input logic RESET,
	input logic Step,
	output logic [DatapathPkg::DataWidth-1:0] Result,
	output logic ResultValid,
	output logic [3:0] Led,
	output logic Done,
	output logic [6:0] SevenSegment,
	output logic [3:0] Enable
);

	DatapathPkg::AluOp aluOp;
	DatapathPkg::Immediate aluImm;
	DatapathPkg::AluFlags aluFlags;
	DatapathPkg::AluFlags ledFlags;

	RegPortIf regPort ();

	ProgramSequencer sequencer
	(
		.Clk(Clk),
		.RESET(RESET),
		.Step(Step),
		.Ctrl(regPort.ctrl),
		.Op(aluOp),
		.Imm(aluImm),
		.AluFlagsIn(aluFlags),
		.Result(Result),
		.ResultValid(ResultValid),
		.Led(ledFlags),
		.Done(Done)
	);

	RegisterFile regFile (.Clk(Clk), .RESET(RESET), .Regs(regPort.regs));

	Alu alu (.Operands(regPort.operand), .Op(aluOp), .Imm(aluImm), .Flags(aluFlags));

	HexDisplayDriver display
	(
		.Clk(Clk),
		.RESET(RESET),
		.Value(Result),
		.SevenSegment(SevenSegment),
		.Enable(Enable)
	);

	// Carry, Zero, Negative, Overflow from bit 3 down
	assign Led = ledFlags;

endmodule

// ==== src/HexDisplayDriver.sv ====
module HexDisplayDriver
(
	input logic Clk,
	input logic RESET,
	input DatapathPkg::Word Value,
	output logic [6:0] SevenSegment,
	output logic [3:0] Enable
);

	logic [DatapathPkg::RefreshBits-1:0] refreshCount;
	logic [1:0] digitIndex;
	logic [1:0] nextIndex;
	logic [3:0] nibble;
	logic refreshTick;

	assign refreshTick = (refreshCount == '1);

	// First tick after reset starts at digit 0
	assign nextIndex = (Enable == 4'b1111) ? 2'd0 : digitIndex + 2'd1;

	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			refreshCount <= '0;
			digitIndex <= 2'd0;
			Enable <= 4'b1111;
		end
		else
		begin
			refreshCount <= refreshCount + 1'b1;
			if (refreshTick)
			begin
				digitIndex <= nextIndex;
				Enable <= ~(4'b0001 << nextIndex);
			end
		end
	end

	assign nibble = Value[{digitIndex, 2'b00} +: 4];

	// Active-low segments with g in bit 6
	always_comb
	begin
		case (nibble)
			4'h0: SevenSegment = 7'b1000000;
			4'h1: SevenSegment = 7'b1111001;
			4'h2: SevenSegment = 7'b0100100;
			4'h3: SevenSegment = 7'b0110000;
			4'h4: SevenSegment = 7'b0011001;
			4'h5: SevenSegment = 7'b0010010;
			4'h6: SevenSegment = 7'b0000010;
			4'h7: SevenSegment = 7'b1111000;
			4'h8: SevenSegment = 7'b0000000;
			4'h9: SevenSegment = 7'b0010000;
			4'hA: SevenSegment = 7'b0001000;
			4'hB: SevenSegment = 7'b0000011;
			4'hC: SevenSegment = 7'b1000110;
			4'hD: SevenSegment = 7'b0100001;
			4'hE: SevenSegment = 7'b0000110;
			default: SevenSegment = 7'b0001110;
		endcase
	end

endmodule

// ==== src/ProgramSequencer.sv ====
module ProgramSequencer
(
	input logic Clk,
	input logic RESET,
	input logic Step,
	RegPortIf.ctrl Ctrl,
	output DatapathPkg::AluOp Op,
	output DatapathPkg::Immediate Imm,
	input DatapathPkg::AluFlags AluFlagsIn,
	output DatapathPkg::Word Result,
	output logic ResultValid,
	output DatapathPkg::AluFlags Led,
	output logic Done
);

	DatapathPkg::StepIndex stepCount;
	DatapathPkg::SeqState state;
	DatapathPkg::RegAddr writeAddr;
	logic writeEnable;

	// Destination is always the low four bits of the step
	assign writeAddr = stepCount[DatapathPkg::RegAddrWidth-1:0];
	assign writeEnable = Step && (state == DatapathPkg::RUN);
	assign Done = (state == DatapathPkg::DONE);

	assign Ctrl.WriteAddr = writeAddr;
	assign Ctrl.WriteEnable = writeEnable;

	////////////////////////////////////////////////////////////////////////////
	// Built-in program
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		Ctrl.ReadA = '0;
		Ctrl.ReadB = '0;
		Op = DatapathPkg::ADD;
		Imm = '0;

		case (stepCount)
			// Seed r0 and r1 with r15 + 1 while r15 is still zero
			5'd0, 5'd1:
			begin
				Ctrl.ReadA = 4'd15;
				Op = DatapathPkg::ADDI;
				Imm = 8'd1;
			end
			5'd16:
			begin
				Ctrl.ReadA = 4'd15;
				Ctrl.ReadB = 4'd14;
				Op = DatapathPkg::SUB;
			end
			5'd17:
			begin
				Ctrl.ReadA = 4'd15;
				Ctrl.ReadB = 4'd14;
				Op = DatapathPkg::AND;
			end
			5'd18:
			begin
				Ctrl.ReadA = 4'd13;
				Ctrl.ReadB = 4'd12;
				Op = DatapathPkg::OR;
			end
			5'd19:
			begin
				Ctrl.ReadA = 4'd11;
				Ctrl.ReadB = 4'd10;
				Op = DatapathPkg::XOR;
			end
			5'd20:
			begin
				Ctrl.ReadA = 4'd9;
				Op = DatapathPkg::SHL;
			end
			5'd21:
			begin
				Ctrl.ReadA = 4'd8;
				Op = DatapathPkg::SHR;
			end
			// Negative result with borrow
			5'd22:
			begin
				Ctrl.ReadA = 4'd0;
				Ctrl.ReadB = 4'd15;
				Op = DatapathPkg::SUB;
			end
			5'd23:
			begin
				Ctrl.ReadA = 4'd15;
				Op = DatapathPkg::ADDI;
				Imm = 8'hFF;
			end
			// Fibonacci steps 2 to 15 add the two previous registers
			default:
			begin
				Ctrl.ReadA = writeAddr - DatapathPkg::RegAddr'(2);
				Ctrl.ReadB = writeAddr - DatapathPkg::RegAddr'(1);
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Step counter, state and result capture
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			stepCount <= '0;
			state <= DatapathPkg::RUN;
			Result <= '0;
			Led <= '0;
			ResultValid <= 1'b0;
		end
		else
		begin
			ResultValid <= writeEnable;
			if (writeEnable)
			begin
				Result <= Ctrl.WriteData;
				Led <= AluFlagsIn;
				// Counter parks on the last step
				if (stepCount == DatapathPkg::StepIndex'(DatapathPkg::ProgramLength - 1))
					state <= DatapathPkg::DONE;
				else
					stepCount <= stepCount + 1'b1;
			end
		end
	end

endmodule

// ==== src/RegPortIf.sv ====
interface RegPortIf;

	DatapathPkg::RegAddr ReadA;
	DatapathPkg::RegAddr ReadB;
	DatapathPkg::RegAddr WriteAddr;
	logic WriteEnable;
	DatapathPkg::Word DataA;
	DatapathPkg::Word DataB;
	DatapathPkg::Word WriteData;

	// Sequencer side also sees the data being written
	modport ctrl (output ReadA, ReadB, WriteAddr, WriteEnable, input WriteData);

	// Register file side
	modport regs (input ReadA, ReadB, WriteAddr, WriteEnable, WriteData,
		output DataA, DataB);

	// ALU side
	modport operand (input DataA, DataB, output WriteData);

endinterface

// ==== src/RegisterFile.sv ====
module RegisterFile
(
	input logic Clk,
	input logic RESET,
	RegPortIf.regs Regs
);

	DatapathPkg::Word registers [DatapathPkg::RegCount];

	// Single write port cleared on reset
	always_ff @(posedge Clk)
	begin
		if (RESET)
		begin
			for (int i = 0; i < DatapathPkg::RegCount; i++)
			begin
				registers[i] <= '0;
			end
		end
		else if (Regs.WriteEnable)
		begin
			registers[Regs.WriteAddr] <= Regs.WriteData;
		end
	end

	// Two asynchronous read ports
	always_comb
	begin
		Regs.DataA = registers[Regs.ReadA];
		Regs.DataB = registers[Regs.ReadB];
	end

endmodule

// ==== verification/FibonacciDatapathTb.sv ====
module FibonacciDatapathTb;

	localparam int ClockPeriod = 40;
	localparam int ResetCycles = 10;
	localparam int RefreshPeriod = 1 << DatapathPkg::RefreshBits;
	localparam int WatchdogCycles = DatapathPkg::ProgramLength * 6 + 8 * RefreshPeriod
		+ ResetCycles;

	// Active-low segments with g in bit 6
	localparam logic [6:0] HexPatterns [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000, 7'b0011001, 7'b0010010,
		7'b0000010, 7'b1111000, 7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110};

	typedef struct packed
	{
		DatapathPkg::AluOp op;
		DatapathPkg::RegAddr dest;
		DatapathPkg::RegAddr srcA;
		DatapathPkg::RegAddr srcB;
		DatapathPkg::Immediate imm;
	} ProgramEntry;

	logic Clk;
	logic RESET;
	logic Step;
	logic [DatapathPkg::DataWidth-1:0] Result;
	logic ResultValid;
	logic [3:0] Led;
	logic Done;
	logic [6:0] SevenSegment;
	logic [3:0] Enable;

	ProgramEntry programTable [DatapathPkg::ProgramLength];
	DatapathPkg::Word model [DatapathPkg::RegCount];
	integer seed = 32'hfb17_7c2c;
	int valueErrors = 0;
	int flagErrors = 0;
	int segmentErrors = 0;
	int protocolErrors = 0;

	FibonacciDatapath UUT
	(
		.Clk(Clk),
		.RESET(RESET),
		.Step(Step),
		.Result(Result),
		.ResultValid(ResultValid),
		.Led(Led),
		.Done(Done),
		.SevenSegment(SevenSegment),
		.Enable(Enable)
	);

	always #(ClockPeriod / 2) Clk = ~Clk;

	////////////////////////////////////////////////////////////////////////////
	// Program table, reference model and compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic loadProgram();
		programTable[0] = '{DatapathPkg::ADDI, 4'd0, 4'd15, 4'd0, 8'd1};
		programTable[1] = '{DatapathPkg::ADDI, 4'd1, 4'd15, 4'd0, 8'd1};
		for (int n = 2; n < 16; n++)
		begin
			programTable[DatapathPkg::StepIndex'(n)] = '{DatapathPkg::ADD,
				DatapathPkg::RegAddr'(n), DatapathPkg::RegAddr'(n - 2),
				DatapathPkg::RegAddr'(n - 1), 8'd0};
		end
		programTable[16] = '{DatapathPkg::SUB, 4'd0, 4'd15, 4'd14, 8'd0};
		programTable[17] = '{DatapathPkg::AND, 4'd1, 4'd15, 4'd14, 8'd0};
		programTable[18] = '{DatapathPkg::OR, 4'd2, 4'd13, 4'd12, 8'd0};
		programTable[19] = '{DatapathPkg::XOR, 4'd3, 4'd11, 4'd10, 8'd0};
		programTable[20] = '{DatapathPkg::SHL, 4'd4, 4'd9, 4'd0, 8'd0};
		programTable[21] = '{DatapathPkg::SHR, 4'd5, 4'd8, 4'd0, 8'd0};
		programTable[22] = '{DatapathPkg::SUB, 4'd6, 4'd0, 4'd15, 8'd0};
		programTable[23] = '{DatapathPkg::ADDI, 4'd7, 4'd15, 4'd0, 8'hFF};
	endtask

	// Borrow shows up as a negative integer difference
	task automatic computeExpected(input DatapathPkg::AluOp op, input DatapathPkg::Word a,
		input DatapathPkg::Word b, output DatapathPkg::Word res,
		output DatapathPkg::AluFlags flags);
		int wideSum;
		int signedSum;
		flags = '0;
		res = '0;
		case (op)
			DatapathPkg::ADD, DatapathPkg::ADDI:
			begin
				wideSum = int'(a) + int'(b);
				signedSum = int'($signed(a)) + int'($signed(b));
				res = DatapathPkg::Word'(wideSum);
				flags.Carry = (wideSum > 65535);
				flags.Overflow = (signedSum > 32767) || (signedSum < -32768);
			end
			DatapathPkg::SUB:
			begin
				wideSum = int'(a) - int'(b);
				signedSum = int'($signed(a)) - int'($signed(b));
				res = DatapathPkg::Word'(wideSum);
				flags.Carry = (wideSum < 0);
				flags.Overflow = (signedSum > 32767) || (signedSum < -32768);
			end
			DatapathPkg::AND: res = a & b;
			DatapathPkg::OR: res = a | b;
			DatapathPkg::XOR: res = a ^ b;
			DatapathPkg::SHL:
			begin
				res = {a[DatapathPkg::SignBit-1:0], 1'b0};
				flags.Carry = a[DatapathPkg::SignBit];
			end
			DatapathPkg::SHR:
			begin
				res = {1'b0, a[DatapathPkg::SignBit:1]};
				flags.Carry = a[0];
			end
			default: res = '0;
		endcase
		flags.Zero = (res == '0);
		flags.Negative = res[DatapathPkg::SignBit];
	endtask

	task automatic checkWord(input string what, input DatapathPkg::Word actual,
		input DatapathPkg::Word expected);
		if (actual !== expected)
		begin
			valueErrors++;
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, actual,
				expected);
		end
	endtask

	task automatic checkFlags(input string what, input DatapathPkg::AluFlags actual,
		input DatapathPkg::AluFlags expected);
		if (actual !== expected)
		begin
			flagErrors++;
			$display("CHECK FAILED at %0t: %s CZNV is %b, expected %b", $time, what, actual,
				expected);
		end
	endtask

	task automatic checkSegments(input logic [1:0] digit, input logic [6:0] actual,
		input logic [6:0] expected);
		if (actual !== expected)
		begin
			segmentErrors++;
			$display("CHECK FAILED at %0t: digit %0d shows %b, expected %b", $time, digit,
				actual, expected);
		end
	endtask

	task automatic protocolError(input string message);
		protocolErrors++;
		$display("Protocol error at %0t: %s", $time, message);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		int gap;
		DatapathPkg::Word a;
		DatapathPkg::Word b;
		DatapathPkg::Word expResult;
		DatapathPkg::Word finalResult;
		DatapathPkg::AluFlags expFlags;
		ProgramEntry entry;
		logic [1:0] digit;
		logic [1:0] lastDigit;
		logic [3:0] seenDigits;
		Clk = 1'b0;
		RESET = 1'b1;
		Step = 1'b0;
		loadProgram();
		for (int r = 0; r < DatapathPkg::RegCount; r++)
			model[DatapathPkg::RegAddr'(r)] = '0;
		repeat (ResetCycles) @(posedge Clk);
		RESET <= 1'b0;

		@(negedge Clk);
		checkWord("Result after reset", Result, '0);
		checkFlags("Led after reset", Led, '0);
		if (ResultValid !== 1'b0 || Done !== 1'b0)
			protocolError("ResultValid or Done is high right after reset");
		if (Enable !== 4'b1111)
			protocolError("a digit is enabled before the first refresh tick");

		gap = {$random(seed)} % 4;
		repeat (gap) @(posedge Clk);
		@(posedge Clk);
		Step <= 1'b1;

		for (int s = 0; s < DatapathPkg::ProgramLength; s++)
		begin
			entry = programTable[DatapathPkg::StepIndex'(s)];
			a = model[entry.srcA];
			b = (entry.op == DatapathPkg::ADDI) ? DatapathPkg::Word'(entry.imm)
				: model[entry.srcB];
			computeExpected(entry.op, a, b, expResult, expFlags);
			model[entry.dest] = expResult;

			// Step is sampled at this edge and stays high for a back-to-back step
			@(posedge Clk);
			gap = {$random(seed)} % 4;
			if (s == DatapathPkg::ProgramLength - 1 || gap > 0)
				Step <= 1'b0;
			@(negedge Clk);
			if (ResultValid !== 1'b1)
				protocolError($sformatf("no ResultValid one cycle after step %0d", s));
			checkWord($sformatf("Result of step %0d", s), Result, expResult);
			checkFlags($sformatf("Led of step %0d", s), Led, expFlags);

			if (s < DatapathPkg::ProgramLength - 1)
			begin
				for (int i = 0; i < gap; i++)
				begin
					@(posedge Clk);
					if (i == gap - 1)
						Step <= 1'b1;
					@(negedge Clk);
					if (ResultValid !== 1'b0)
						protocolError("ResultValid stays high longer than one cycle");
				end
			end
		end

		finalResult = expResult;
		if (Done !== 1'b1)
			protocolError("Done did not rise after the last step");

		// Steps after Done must be ignored
		for (int i = 0; i < 3; i++)
		begin
			@(posedge Clk);
			Step <= 1'b1;
			@(posedge Clk);
			Step <= 1'b0;
			@(negedge Clk);
			if (ResultValid !== 1'b0)
				protocolError("a Step after Done produced ResultValid");
			if (Done !== 1'b1)
				protocolError("Done dropped after a late Step");
			checkWord("Result after Done", Result, finalResult);
		end

		////////////////////////////////////////////////////////////////////////////
		// Display scan
		////////////////////////////////////////////////////////////////////////////

		seenDigits = '0;
		lastDigit = 2'd0;
		repeat (6 * RefreshPeriod)
		begin
			@(negedge Clk);
			if (Enable === 4'b1111)
			begin
				if (seenDigits !== 4'b0000)
					protocolError("all digits went dark after the scan started");
			end
			else
			begin
				case (Enable)
					4'b1110: digit = 2'd0;
					4'b1101: digit = 2'd1;
					4'b1011: digit = 2'd2;
					4'b0111: digit = 2'd3;
					default:
					begin
						digit = 2'd0;
						protocolError($sformatf("Enable %b is not a single active digit",
							Enable));
					end
				endcase
				// Digits rotate upward from digit 0
				if (seenDigits == 4'b0000 && digit != 2'd0)
					protocolError("the scan did not start at digit 0");
				else if (seenDigits != 4'b0000 && digit != lastDigit
					&& digit != lastDigit + 2'd1)
					protocolError("the scan skipped a digit");
				lastDigit = digit;
				seenDigits[digit] = 1'b1;
				checkSegments(digit, SevenSegment,
					HexPatterns[finalResult[{digit, 2'b00} +: 4]]);
			end
		end
		if (seenDigits !== 4'b1111)
			protocolError("the display did not scan all four digits");

		$display("Errors: value %0d, flags %0d, segments %0d, protocol %0d", valueErrors,
			flagErrors, segmentErrors, protocolErrors);
		if (valueErrors + flagErrors + segmentErrors + protocolErrors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WatchdogCycles * ClockPeriod);
		$display("Simulation timed out after %0d cycles", WatchdogCycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
